/* Bender.yml */
package:
  name: tsc_exec

sources:
  - logic/tsc_pkg.sv
  - logic/exec_if.sv
  - logic/alu_control.sv
  - logic/alu.sv
  - logic/register_file.sv
  - logic/execute_stage.sv
  - logic/apb_exec_regs.sv
  - logic/tsc_exec_top.sv
  - target: test
    files:
      - sim/tb_tsc_exec_properties.sv
      - sim/tb_tsc_exec.sv

/* all.f */
logic/tsc_pkg.sv
logic/exec_if.sv
logic/alu_control.sv
logic/alu.sv
logic/register_file.sv
logic/execute_stage.sv
logic/apb_exec_regs.sv
logic/tsc_exec_top.sv
sim/tb_tsc_exec_properties.sv
sim/tb_tsc_exec.sv

/* logic/alu.sv */
`default_nettype none

module alu (
	input  logic [tsc_pkg::word_w-1:0] i_a,
	input  logic [tsc_pkg::word_w-1:0] i_b,
	input  tsc_pkg::opcode_e           i_opcode,
	input  tsc_pkg::alu_func_e         i_alu_func,
	input  tsc_pkg::inst_func_e        i_inst_func,
	output logic [tsc_pkg::word_w-1:0] o_result,
	output logic                       o_bcond
);
	import tsc_pkg::*;

	logic [word_w-1:0] sum;
	logic [word_w-1:0] diff;

	assign sum  = i_a + i_b;
	assign diff = i_a - i_b;

	always_comb begin
		o_result = sum;
		o_bcond  = 1'b0;
		case (i_alu_func)
			FUNC_ADD: begin
				if (i_inst_func == INST_JPR || i_inst_func == INST_JRL) begin
					o_result = i_a; // jump target is rs itself
				end
			end
			FUNC_SUB: begin
				o_result = diff;
				case (i_opcode)
					OP_BNE:  o_bcond = (diff != '0);
					OP_BEQ:  o_bcond = (diff == '0);
					OP_BGZ:  o_bcond = ($signed(i_a) > 0); // rs is a signed value
					OP_BLZ:  o_bcond = ($signed(i_a) < 0);
					default: o_bcond = 1'b0;
				endcase
			end
			FUNC_AND: begin
				o_result = i_a & i_b;
			end
			FUNC_ORR: begin
				o_result = i_a | i_b;
			end
			FUNC_NOT: begin
				o_result = ~i_a;
			end
			FUNC_TCP: begin
				o_result = ~i_a + 1'b1;
			end
			FUNC_SHL: begin
				if (i_opcode == OP_LHI) begin
					o_result = i_b << 8; // immediate into the upper byte
				end else begin
					o_result = i_a << 1;
				end
			end
			FUNC_SHR: begin
				o_result = {i_a[word_w-1], i_a[word_w-1:1]}; // sign bit is kept
			end
			default: begin
				o_result = sum;
			end
		endcase
	end

endmodule

`default_nettype wire

/* logic/alu_control.sv */
`default_nettype none

module alu_control (
	input  logic [tsc_pkg::word_w-1:0] i_instr,
	output tsc_pkg::opcode_e           o_opcode,
	output tsc_pkg::alu_func_e         o_alu_func,
	output tsc_pkg::inst_func_e        o_inst_func
);
	import tsc_pkg::*;

	logic [op_hi-op_lo:0]     op_field;
	logic [func_hi-func_lo:0] func_field;
	opcode_e                  op;
	inst_func_e               func;

	assign op_field   = i_instr[op_hi:op_lo];
	assign func_field = i_instr[func_hi:func_lo];
	assign op         = opcode_e'(op_field); // unlisted codes pass through as a flag
	assign func       = inst_func_e'(func_field);

	always_comb begin
		o_opcode    = op;
		o_alu_func  = FUNC_ADD;
		o_inst_func = INST_ADD; // immediate bits must not look like JPR
		case (op)
			OP_ALU: begin
				o_inst_func = func; // an unknown func stays visible so it is not written back
				case (func)
					INST_SUB: o_alu_func = FUNC_SUB;
					INST_AND: o_alu_func = FUNC_AND;
					INST_ORR: o_alu_func = FUNC_ORR;
					INST_NOT: o_alu_func = FUNC_NOT;
					INST_TCP: o_alu_func = FUNC_TCP;
					INST_SHL: o_alu_func = FUNC_SHL;
					INST_SHR: o_alu_func = FUNC_SHR;
					default:  o_alu_func = FUNC_ADD; // ADD, JPR, JRL
				endcase
			end
			OP_ADI, OP_LWD, OP_SWD: begin
				o_alu_func = FUNC_ADD; // address or sum with the immediate
			end
			OP_ORI: begin
				o_alu_func = FUNC_ORR;
			end
			OP_LHI: begin
				o_alu_func = FUNC_SHL;
			end
			OP_BNE, OP_BEQ, OP_BGZ, OP_BLZ: begin
				o_alu_func = FUNC_SUB;
			end
			default: begin
				o_alu_func = FUNC_ADD;
			end
		endcase
	end

endmodule

`default_nettype wire

/* logic/apb_exec_regs.sv */
`default_nettype none

module apb_exec_regs (
	input  logic                           i_clk,
	input  logic                           i_reset,
	input  logic                           i_psel,
	input  logic                           i_penable,
	input  logic                           i_pwrite,
	input  logic [tsc_pkg::apb_addr_w-1:0] i_paddr,
	input  logic [tsc_pkg::word_w-1:0]     i_pwdata,
	output logic [tsc_pkg::word_w-1:0]     o_prdata,
	output logic                           o_pready,
	output logic                           o_pslverr,
	exec_if.host                           host,
	output logic [tsc_pkg::reg_addr_w-1:0] o_host_addr,
	input  logic [tsc_pkg::word_w-1:0]     i_host_data,
	output logic                           o_host_we,
	output logic [tsc_pkg::word_w-1:0]     o_host_wdata
);
	import tsc_pkg::*;

	logic              sel_instr;
	logic              sel_status;
	logic              sel_result;
	logic              sel_reg;
	logic              addr_ok;
	logic              instr_wr;
	logic [word_w-1:0] instr_q;
	logic              start_q;

	assign sel_instr  = (i_paddr == addr_instr);
	assign sel_status = (i_paddr == addr_status);
	assign sel_result = (i_paddr == addr_result);
	assign sel_reg    = ((i_paddr & addr_reg_mask) == addr_reg0);
	assign addr_ok    = sel_instr | sel_status | sel_result | sel_reg;

	// #########################################################################
	// handshake

	assign o_pready  = i_psel && i_penable && !(host.start || host.busy); // wait out the stage
	assign o_pslverr = o_pready && !addr_ok;
	assign instr_wr  = o_pready && i_pwrite && sel_instr;

	assign o_host_addr  = i_paddr[reg_addr_w+1:2];
	assign o_host_we    = o_pready && i_pwrite && sel_reg;
	assign o_host_wdata = i_pwdata;

	always_comb begin
		o_prdata = '0;
		if (sel_instr) begin
			o_prdata = instr_q;
		end else if (sel_status) begin
			o_prdata = {{(word_w-2){1'b0}}, host.bcond, host.busy};
		end else if (sel_result) begin
			o_prdata = host.result;
		end else if (sel_reg) begin
			o_prdata = i_host_data;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			instr_q <= '0;
			start_q <= 1'b0;
		end else begin
			start_q <= instr_wr; // one cycle after the write completes
			if (instr_wr) begin
				instr_q <= i_pwdata;
			end
		end
	end

	assign host.start = start_q;
	assign host.instr = instr_q;

endmodule

`default_nettype wire

/* logic/exec_if.sv */
`default_nettype none

interface exec_if;
	import tsc_pkg::*;

	logic              start; // one-cycle pulse, only while idle
	logic [word_w-1:0] instr;
	logic              busy;
	logic [word_w-1:0] result;
	logic              bcond;

	modport host (output start, output instr, input busy, input result, input bcond);

	modport exec (input start, input instr, output busy, output result, output bcond);

endinterface

`default_nettype wire

/* logic/execute_stage.sv */
`default_nettype none

module execute_stage (
	input  logic                           i_clk,
	input  logic                           i_reset,
	exec_if.exec                           exec,
	output logic [tsc_pkg::reg_addr_w-1:0] o_rs_addr,
	output logic [tsc_pkg::reg_addr_w-1:0] o_rt_addr,
	input  logic [tsc_pkg::word_w-1:0]     i_rs_data,
	input  logic [tsc_pkg::word_w-1:0]     i_rt_data,
	output logic                           o_wb_en,
	output logic [tsc_pkg::reg_addr_w-1:0] o_wb_addr,
	output logic [tsc_pkg::word_w-1:0]     o_wb_data
);
	import tsc_pkg::*;

	typedef enum logic [1:0] {IDLE, EXEC, WB} state_e;

	state_e                state;
	logic [word_w-1:0]     instr_q;
	opcode_e               opcode;
	alu_func_e             alu_func;
	inst_func_e            inst_func;
	logic [imm_w-1:0]      imm;
	logic [word_w-1:0]     operand_b;
	logic [word_w-1:0]     alu_result;
	logic                  alu_bcond;
	logic                  wb_valid;
	logic [reg_addr_w-1:0] wb_target;
	logic [word_w-1:0]     result_q;
	logic                  bcond_q;
	logic                  wb_en_q;
	logic [reg_addr_w-1:0] wb_addr_q;

	alu_control u_alu_control (
		.i_instr     (instr_q),
		.o_opcode    (opcode),
		.o_alu_func  (alu_func),
		.o_inst_func (inst_func)
	);

	assign o_rs_addr = instr_q[rs_hi:rs_lo];
	assign o_rt_addr = instr_q[rt_hi:rt_lo];
	assign imm       = instr_q[imm_hi:imm_lo];

	// #########################################################################
	// operand select and write-back target

	always_comb begin
		case (opcode)
			OP_ADI, OP_LWD, OP_SWD: operand_b = {{(word_w-imm_w){imm[imm_w-1]}}, imm};
			OP_ORI, OP_LHI:         operand_b = {{(word_w-imm_w){1'b0}}, imm};
			default:                operand_b = i_rt_data; // ALU type and branches
		endcase
	end

	alu u_alu (
		.i_a         (i_rs_data),
		.i_b         (operand_b),
		.i_opcode    (opcode),
		.i_alu_func  (alu_func),
		.i_inst_func (inst_func),
		.o_result    (alu_result),
		.o_bcond     (alu_bcond)
	);

	always_comb begin
		wb_valid  = 1'b0;
		wb_target = instr_q[rt_hi:rt_lo];
		case (opcode)
			OP_ALU: begin
				wb_target = instr_q[rd_hi:rd_lo];
				wb_valid  = inst_func inside {INST_ADD, INST_SUB, INST_AND, INST_ORR,
					INST_NOT, INST_TCP, INST_SHL, INST_SHR};
			end
			OP_ADI, OP_ORI, OP_LHI: wb_valid = 1'b1;
			default:                wb_valid = 1'b0; // branches, memory ops, unknown opcodes
		endcase
	end

	// #########################################################################
	// sequencer

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			state    <= IDLE;
			result_q <= '0;
			bcond_q  <= 1'b0;
			wb_en_q  <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (exec.start) begin
						state <= EXEC;
					end
				end
				EXEC: begin
					result_q <= alu_result;
					bcond_q  <= alu_bcond;
					wb_en_q  <= wb_valid;
					state    <= WB;
				end
				default: begin
					state <= IDLE; // write-back happens on leaving WB
				end
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (exec.start) begin
			instr_q <= exec.instr;
		end
		if (state == EXEC) begin
			wb_addr_q <= wb_target;
		end
	end

	assign o_wb_en     = (state == WB) && wb_en_q;
	assign o_wb_addr   = wb_addr_q;
	assign o_wb_data   = result_q;
	assign exec.busy   = (state != IDLE);
	assign exec.result = result_q;
	assign exec.bcond  = bcond_q;

endmodule

`default_nettype wire

/* logic/register_file.sv */
`default_nettype none

module register_file (
	input  logic                           i_clk,
	input  logic                           i_reset,
	input  logic [tsc_pkg::reg_addr_w-1:0] i_rs_addr,
	input  logic [tsc_pkg::reg_addr_w-1:0] i_rt_addr,
	output logic [tsc_pkg::word_w-1:0]     o_rs_data,
	output logic [tsc_pkg::word_w-1:0]     o_rt_data,
	input  logic [tsc_pkg::reg_addr_w-1:0] i_host_addr,
	output logic [tsc_pkg::word_w-1:0]     o_host_data,
	input  logic                           i_wb_en,
	input  logic [tsc_pkg::reg_addr_w-1:0] i_wb_addr,
	input  logic [tsc_pkg::word_w-1:0]     i_wb_data,
	input  logic                           i_host_we,
	input  logic [tsc_pkg::word_w-1:0]     i_host_wdata
);
	import tsc_pkg::*;

	logic [word_w-1:0] regs [2**reg_addr_w];

	assign o_rs_data   = regs[i_rs_addr];
	assign o_rt_data   = regs[i_rt_addr];
	assign o_host_data = regs[i_host_addr];

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			for (int i = 0; i < 2**reg_addr_w; i++) begin
				regs[i] <= '0;
			end
		end else if (i_wb_en) begin
			regs[i_wb_addr] <= i_wb_data; // write-back wins over the host
		end else if (i_host_we) begin
			regs[i_host_addr] <= i_host_wdata;
		end
	end

endmodule

`default_nettype wire

/* logic/tsc_exec_top.sv */
`default_nettype none

module tsc_exec_top (
	input  logic                           i_clk,
	input  logic                           i_reset,
	input  logic                           i_psel,
	input  logic                           i_penable,
	input  logic                           i_pwrite,
	input  logic [tsc_pkg::apb_addr_w-1:0] i_paddr,
	input  logic [tsc_pkg::word_w-1:0]     i_pwdata,
	output logic [tsc_pkg::word_w-1:0]     o_prdata,
	output logic                           o_pready,
	output logic                           o_pslverr
);
	import tsc_pkg::*;

	logic [reg_addr_w-1:0] rs_addr;
	logic [reg_addr_w-1:0] rt_addr;
	logic [word_w-1:0]     rs_data;
	logic [word_w-1:0]     rt_data;
	logic                  wb_en;
	logic [reg_addr_w-1:0] wb_addr;
	logic [word_w-1:0]     wb_data;
	logic [reg_addr_w-1:0] host_addr;
	logic [word_w-1:0]     host_data;
	logic                  host_we;
	logic [word_w-1:0]     host_wdata;

	exec_if u_exec_if ();

	apb_exec_regs u_apb_exec_regs (
		.i_clk        (i_clk),
		.i_reset      (i_reset),
		.i_psel       (i_psel),
		.i_penable    (i_penable),
		.i_pwrite     (i_pwrite),
		.i_paddr      (i_paddr),
		.i_pwdata     (i_pwdata),
		.o_prdata     (o_prdata),
		.o_pready     (o_pready),
		.o_pslverr    (o_pslverr),
		.host         (u_exec_if.host),
		.o_host_addr  (host_addr),
		.i_host_data  (host_data),
		.o_host_we    (host_we),
		.o_host_wdata (host_wdata)
	);

	execute_stage u_execute_stage (
		.i_clk     (i_clk),
		.i_reset   (i_reset),
		.exec      (u_exec_if.exec),
		.o_rs_addr (rs_addr),
		.o_rt_addr (rt_addr),
		.i_rs_data (rs_data),
		.i_rt_data (rt_data),
		.o_wb_en   (wb_en),
		.o_wb_addr (wb_addr),
		.o_wb_data (wb_data)
	);

	register_file u_register_file (
		.i_clk        (i_clk),
		.i_reset      (i_reset),
		.i_rs_addr    (rs_addr),
		.i_rt_addr    (rt_addr),
		.o_rs_data    (rs_data),
		.o_rt_data    (rt_data),
		.i_host_addr  (host_addr),
		.o_host_data  (host_data),
		.i_wb_en      (wb_en),
		.i_wb_addr    (wb_addr),
		.i_wb_data    (wb_data),
		.i_host_we    (host_we),
		.i_host_wdata (host_wdata)
	);

endmodule

`default_nettype wire

/* logic/tsc_pkg.sv */
`default_nettype none

package tsc_pkg;

	// #########################################################################
	// widths and instruction fields

	localparam int word_w     = 16;
	localparam int reg_addr_w = 2; // four registers
	localparam int apb_addr_w = 8;

	localparam int op_hi   = 15;
	localparam int op_lo   = 12;
	localparam int rs_hi   = 11;
	localparam int rs_lo   = 10;
	localparam int rt_hi   = 9;
	localparam int rt_lo   = 8;
	localparam int rd_hi   = 7;
	localparam int rd_lo   = 6;
	localparam int func_hi = 5;
	localparam int func_lo = 0;
	localparam int imm_hi  = 7;
	localparam int imm_lo  = 0;
	localparam int imm_w   = imm_hi - imm_lo + 1;

	// #########################################################################
	// APB register map

	localparam logic [apb_addr_w-1:0] addr_instr    = 8'h00;
	localparam logic [apb_addr_w-1:0] addr_status   = 8'h04;
	localparam logic [apb_addr_w-1:0] addr_result   = 8'h08;
	localparam logic [apb_addr_w-1:0] addr_reg0     = 8'h10;
	localparam logic [apb_addr_w-1:0] addr_reg_mask = 8'hF3; // keeps the window, drops the index

	// #########################################################################
	// encodings

	typedef enum logic [3:0] {
		OP_BNE = 4'd0,
		OP_BEQ = 4'd1,
		OP_BGZ = 4'd2,
		OP_BLZ = 4'd3,
		OP_ADI = 4'd4,
		OP_ORI = 4'd5,
		OP_LHI = 4'd6,
		OP_LWD = 4'd7,
		OP_SWD = 4'd8,
		OP_ALU = 4'd15
	} opcode_e;

	typedef enum logic [2:0] {
		FUNC_ADD,
		FUNC_SUB,
		FUNC_AND,
		FUNC_ORR,
		FUNC_NOT,
		FUNC_TCP,
		FUNC_SHL,
		FUNC_SHR
	} alu_func_e;

	typedef enum logic [5:0] {
		INST_ADD = 6'd0,
		INST_SUB = 6'd1,
		INST_AND = 6'd2,
		INST_ORR = 6'd3,
		INST_NOT = 6'd4,
		INST_TCP = 6'd5,
		INST_SHL = 6'd6,
		INST_SHR = 6'd7,
		INST_JPR = 6'd25,
		INST_JRL = 6'd26
	} inst_func_e;

endpackage

`default_nettype wire

/* sim/tb_tsc_exec.sv */
`default_nettype none

module tb_tsc_exec;
	import tsc_pkg::*;

	localparam int n_cases         = 36; // instruction runs and register checks
	localparam int cycles_per_case = 200;
	localparam int margin_cycles   = 500;
	localparam int apb_wait_max    = 50;

	logic        clk;
	logic        reset;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [7:0]  paddr;
	logic [15:0] pwdata;
	logic [15:0] prdata;
	logic        pready;
	logic        pslverr;

	logic [15:0] mirror [4]; // what the register file should hold
	int          error_count;
	int          check_count;
	int unsigned seed_draw;

	tsc_exec_top u_tsc_exec_top (
		.i_clk     (clk),
		.i_reset   (reset),
		.i_psel    (psel),
		.i_penable (penable),
		.i_pwrite  (pwrite),
		.i_paddr   (paddr),
		.i_pwdata  (pwdata),
		.o_prdata  (prdata),
		.o_pready  (pready),
		.o_pslverr (pslverr)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		repeat (n_cases * cycles_per_case + margin_cycles) @(posedge clk);
		$display("timeout: the run did not finish within the cycle budget");
		$display("TEST FAILED");
		$finish;
	end

	// ##########################################################################
	// bus access and checking

	task automatic apb_transfer(input logic write, input logic [7:0] addr,
		input logic [15:0] wdata, output logic [15:0] rdata, output logic err,
		output int waits);
		logic done;
		@(negedge clk);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = write;
		paddr   = addr;
		pwdata  = wdata;
		@(negedge clk);
		penable = 1'b1;
		waits   = 0;
		done    = 1'b0;
		rdata   = '0;
		err     = 1'b0;
		while (!done) begin
			@(posedge clk);
			if (pready) begin
				rdata = prdata;
				err   = pslverr;
				done  = 1'b1;
			end else begin
				waits++;
				if (waits > apb_wait_max) begin
					$display("APB transfer to address %h never got pready", addr);
					error_count++;
					done = 1'b1;
				end
			end
		end
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [15:0] data,
		output logic err);
		logic [15:0] unused_data;
		int          unused_waits;
		apb_transfer(1'b1, addr, data, unused_data, err, unused_waits);
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [15:0] data,
		output logic err, output int waits);
		apb_transfer(1'b0, addr, 16'h0000, data, err, waits);
	endtask

	task automatic check_value(input string test_name, input logic [15:0] expected,
		input logic [15:0] actual);
		check_count++;
		if (actual !== expected) begin
			$display("[FAIL] %s: expected %h, actual %h", test_name, expected, actual);
			error_count++;
		end
	endtask

	task automatic read_check(input string test_name, input logic [7:0] addr,
		input logic [15:0] expected);
		logic [15:0] data;
		logic        err;
		int          waits;
		apb_read(addr, data, err, waits);
		check_value(test_name, expected, data);
		if (err) begin
			$display("%s: read of address %h returned a slave error", test_name, addr);
			error_count++;
		end
	endtask

	function automatic logic [7:0] reg_offset(input logic [1:0] idx);
		return addr_reg0 | {4'h0, idx, 2'b00};
	endfunction

	task automatic set_reg(input logic [1:0] idx, input logic [15:0] value);
		logic err;
		apb_write(reg_offset(idx), value, err);
		mirror[idx] = value;
	endtask

	task automatic report_test(input string test_name, input int errors_before);
		$display("%s finished, %0d errors", test_name, error_count - errors_before);
	endtask

	// ##########################################################################
	// instruction set model

	function automatic logic [15:0] alu_word(input logic [1:0] rs, input logic [1:0] rt,
		input logic [1:0] rd, input logic [5:0] func);
		return {4'hF, rs, rt, rd, func};
	endfunction

	function automatic logic [15:0] imm_word(input logic [3:0] op, input logic [1:0] rs,
		input logic [1:0] rt, input logic [7:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic void model_exec(input logic [15:0] instr, output logic [15:0] result,
		output logic bcond, output logic wb_en, output logic [1:0] wb_addr);
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] sext;
		logic [15:0] zext;
		a       = mirror[instr[11:10]];
		b       = mirror[instr[9:8]];
		sext    = {{8{instr[7]}}, instr[7:0]};
		zext    = {8'h00, instr[7:0]};
		result  = a + b;
		bcond   = 1'b0;
		wb_en   = 1'b0;
		wb_addr = instr[9:8]; // immediate forms write rt
		case (instr[15:12])
			4'd15: begin
				wb_addr = instr[7:6];
				wb_en   = 1'b1;
				case (instr[5:0])
					6'd0:         result = a + b;
					6'd1:         result = a - b;
					6'd2:         result = a & b;
					6'd3:         result = a | b;
					6'd4:         result = ~a;
					6'd5:         result = -a;
					6'd6:         result = a << 1;
					6'd7:         result = $signed(a) >>> 1;
					6'd25, 6'd26: begin
						result = a; // jumps only report rs
						wb_en  = 1'b0;
					end
					default:      wb_en = 1'b0;
				endcase
			end
			4'd4: begin
				result = a + sext;
				wb_en  = 1'b1;
			end
			4'd5: begin
				result = a | zext;
				wb_en  = 1'b1;
			end
			4'd6: begin
				result = {instr[7:0], 8'h00};
				wb_en  = 1'b1;
			end
			4'd7, 4'd8: result = a + sext;
			4'd0: begin
				result = a - b;
				bcond  = (a != b);
			end
			4'd1: begin
				result = a - b;
				bcond  = (a == b);
			end
			4'd2: begin
				result = a - b;
				bcond  = ($signed(a) > 0);
			end
			4'd3: begin
				result = a - b;
				bcond  = ($signed(a) < 0);
			end
			default: result = a + b;
		endcase
	endfunction

	task automatic run_case(input string test_name, input logic [15:0] instr);
		logic [15:0] exp_result;
		logic        exp_bcond;
		logic        exp_wb;
		logic [1:0]  exp_addr;
		logic        err;
		model_exec(instr, exp_result, exp_bcond, exp_wb, exp_addr);
		apb_write(addr_instr, instr, err);
		if (exp_wb) begin
			mirror[exp_addr] = exp_result;
		end
		read_check(test_name, addr_result, exp_result);
		read_check(test_name, addr_status, {14'h0000, exp_bcond, 1'b0});
		for (int i = 0; i < 4; i++) begin
			read_check(test_name, reg_offset(i[1:0]), mirror[i]);
		end
	endtask

	// ##########################################################################
	// directed tests

	task automatic test_reset();
		int errors_before;
		errors_before = error_count;
		for (int i = 0; i < 4; i++) begin
			read_check("reset regs", reg_offset(i[1:0]), 16'h0000);
		end
		read_check("reset result", addr_result, 16'h0000);
		read_check("reset status", addr_status, 16'h0000);
		for (int i = 0; i < 4; i++) begin
			set_reg(i[1:0], $urandom());
		end
		for (int i = 0; i < 4; i++) begin
			read_check("reg readback", reg_offset(i[1:0]), mirror[i]);
		end
		report_test("reset", errors_before);
	endtask

	task automatic test_alu();
		int          funcs [10] = '{0, 1, 2, 3, 4, 5, 6, 7, 25, 26};
		int          errors_before;
		logic [15:0] instr;
		errors_before = error_count;
		for (int i = 0; i < 10; i++) begin
			for (int r = 0; r < 4; r++) begin
				set_reg(r[1:0], $urandom());
			end
			instr = alu_word($urandom(), $urandom(), $urandom(), funcs[i][5:0]);
			run_case($sformatf("alu func %0d", funcs[i]), instr);
		end
		report_test("alu", errors_before);
	endtask

	task automatic test_immediate();
		int errors_before;
		errors_before = error_count;
		for (int r = 0; r < 4; r++) begin
			set_reg(r[1:0], $urandom());
		end
		run_case("adi negative", imm_word(OP_ADI, 2'd0, 2'd1, 8'hF0));
		run_case("adi positive", imm_word(OP_ADI, 2'd2, 2'd3, 8'h12));
		run_case("lwd address", imm_word(OP_LWD, 2'd1, 2'd2, 8'h80));
		run_case("swd address", imm_word(OP_SWD, 2'd3, 2'd0, 8'hFF));
		run_case("ori zero ext", imm_word(OP_ORI, 2'd0, 2'd2, 8'h9C));
		run_case("lhi upper", imm_word(OP_LHI, 2'd1, 2'd3, 8'hA5));
		report_test("immediate", errors_before);
	endtask

	task automatic test_branch();
		logic [15:0] rs_vals [4] = '{16'h0005, 16'h1234, 16'h8001, 16'h0000};
		logic [15:0] rt_vals [4] = '{16'h0005, 16'h0007, 16'h0003, 16'h0009};
		int          errors_before;
		errors_before = error_count;
		for (int p = 0; p < 4; p++) begin
			set_reg(2'd1, rs_vals[p]);
			set_reg(2'd2, rt_vals[p]);
			for (int op = 0; op < 4; op++) begin
				run_case($sformatf("branch op %0d pair %0d", op, p),
					imm_word(op[3:0], 2'd1, 2'd2, 8'h00));
			end
		end
		report_test("branch", errors_before);
	endtask

	task automatic test_stall();
		logic [15:0] instr;
		logic [15:0] data;
		logic [15:0] exp_result;
		logic        exp_bcond;
		logic        exp_wb;
		logic [1:0]  exp_addr;
		logic        err;
		int          waits;
		int          errors_before;
		errors_before = error_count;
		set_reg(2'd2, 16'h0100);
		instr = imm_word(OP_ADI, 2'd2, 2'd0, 8'h7F);
		model_exec(instr, exp_result, exp_bcond, exp_wb, exp_addr);
		apb_write(addr_instr, instr, err);
		apb_read(addr_result, data, err, waits); // lands while the stage is busy
		mirror[exp_addr] = exp_result;
		check_value("stall result", exp_result, data);
		if (waits == 0) begin
			$display("stall: the RESULT read right after the INSTR write was not held off");
			error_count++;
		end
		read_check("stall rt", reg_offset(exp_addr), exp_result);
		read_check("instr readback", addr_instr, instr);
		apb_read(8'h0C, data, err, waits);
		check_value("unknown read slverr", 16'h0001, err);
		check_value("idle read waits", 16'h0000, waits[15:0]); // idle reads finish at once
		apb_write(8'h40, 16'hBEEF, err);
		check_value("unknown write slverr", 16'h0001, err);
		apb_write(addr_result, 16'hBEEF, err);
		check_value("result write slverr", 16'h0000, err);
		read_check("result write ignored", addr_result, exp_result);
		report_test("stall", errors_before);
	endtask

	initial begin
		reset       = 1'b1;
		psel        = 1'b0;
		penable     = 1'b0;
		pwrite      = 1'b0;
		paddr       = '0;
		pwdata      = '0;
		error_count = 0;
		check_count = 0;
		for (int i = 0; i < 4; i++) begin
			mirror[i] = '0;
		end
		seed_draw = $urandom(32'h33e8);
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		test_reset();
		test_alu();
		test_immediate();
		test_branch();
		test_stall();

		$display("checks %0d, errors %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sim/tb_tsc_exec_properties.sv */
`default_nettype none

module tb_tsc_exec_properties (
	input logic i_clk,
	input logic i_reset,
	input logic i_start,
	input logic i_busy,
	input logic i_psel,
	input logic i_penable,
	input logic i_pready,
	input logic i_pslverr
);

	start_while_idle: assert property (@(posedge i_clk) disable iff (i_reset)
		i_start |-> !i_busy)
		else $error("start raised while the execute stage is busy");

	busy_two_cycles: assert property (@(posedge i_clk) disable iff (i_reset)
		i_start |=> i_busy ##1 i_busy ##1 !i_busy)
		else $error("busy did not last exactly two cycles after start");

	no_ready_when_busy: assert property (@(posedge i_clk) disable iff (i_reset)
		i_start |-> !i_pready ##1 !i_pready ##1 !i_pready)
		else $error("pready high while an instruction is in flight");

	slverr_in_access: assert property (@(posedge i_clk) disable iff (i_reset)
		i_pslverr |-> (i_psel && i_penable))
		else $error("pslverr high outside an access phase");

endmodule

bind apb_exec_regs tb_tsc_exec_properties u_tb_tsc_exec_properties (
	.i_clk     (i_clk),
	.i_reset   (i_reset),
	.i_start   (host.start),
	.i_busy    (host.busy),
	.i_psel    (i_psel),
	.i_penable (i_penable),
	.i_pready  (o_pready),
	.i_pslverr (o_pslverr)
);

`default_nettype wire
